/* common/macrx_pkg.sv */
// MAC receive package with frame constants, field offsets and the frame phase type
package macrx_pkg;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word16_t;
    typedef logic [31:0] crc_t;

    // --------------------------------------------------
    // Frame markers
    // --------------------------------------------------
    localparam byte_t      PREAMBLE_BYTE = 8'h55;
    localparam byte_t      SFD_BYTE      = 8'hD5;
    localparam byte_t      END_BYTE      = 8'hFD;
    localparam logic [3:0] PREAMBLE_LEN  = 4'd7;

    // Body field offsets, high byte first
    localparam word16_t TICK_OFS  = 16'd10;
    localparam word16_t LEN_OFS   = 16'd12;

    // Body length used until a length field has been received
    localparam word16_t LEN_RESET = 16'h0078;

    // Trailer sizes after the body
    localparam word16_t STATUS_LEN = 16'd2;
    localparam word16_t FCS_LEN    = 16'd4;

    // CRC-32, processed LSB first
    localparam crc_t CRC_POLY = 32'h04C11DB7;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    // --------------------------------------------------
    // Frame phases after the SFD
    // --------------------------------------------------
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_BODY,
        PH_STATUS,
        PH_FCS,
        PH_END,
        PH_DONE
    } frame_phase_t;

endpackage

/* frame_check/frame_tracker.sv */
// Frame tracker, walks the body and trailer phases and checks the frame end
`timescale 1ns/1ns

module frame_tracker (
    input  logic                    clk_125m,
    input  logic                    rst_125m,
    input  logic                    rx_dval,
    input  logic                    rx_eop,
    input  logic                    body_start,
    input  macrx_pkg::byte_t        rx_data,
    output macrx_pkg::frame_phase_t phase,
    output macrx_pkg::word16_t      byte_cnt,
    output logic                    frame_end,
    output logic                    len_err
);
    import macrx_pkg::*;

    word16_t body_len;
    word16_t len_now;
    logic    last_body;
    logic    last_status;
    logic    last_fcs;
    logic    early_eop;
    logic    end_d1;
    logic    end_d2;

    // Length as seen this cycle, the low byte may be arriving right now
    assign len_now     = (byte_cnt == LEN_OFS + 16'd1) ? {body_len[15:8], rx_data} : body_len;
    assign last_body   = (byte_cnt == len_now - 16'd1);
    assign last_status = (byte_cnt == STATUS_LEN - 16'd1);
    assign last_fcs    = (byte_cnt == FCS_LEN - 16'd1);
    assign early_eop   = rx_dval && rx_eop
                         && (phase == PH_BODY || phase == PH_STATUS || phase == PH_FCS);

    // --------------------------------------------------
    // Phase FSM, byte_cnt is the index within a phase
    // --------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            phase     <= PH_IDLE;
            byte_cnt  <= '0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            if (early_eop) begin
                phase     <= PH_IDLE;
                byte_cnt  <= '0;
                frame_end <= 1'b1;
            end else begin
                case (phase)
                    PH_IDLE: begin
                        if (body_start) begin
                            phase    <= PH_BODY;
                            byte_cnt <= '0;
                        end
                    end
                    PH_BODY: begin
                        if (rx_dval && last_body) begin
                            phase    <= PH_STATUS;
                            byte_cnt <= '0;
                        end else if (rx_dval) begin
                            byte_cnt <= byte_cnt + 16'd1;
                        end
                    end
                    PH_STATUS: begin
                        if (rx_dval && last_status) begin
                            phase    <= PH_FCS;
                            byte_cnt <= '0;
                        end else if (rx_dval) begin
                            byte_cnt <= byte_cnt + 16'd1;
                        end
                    end
                    PH_FCS: begin
                        if (rx_dval && last_fcs) begin
                            phase    <= PH_END;
                            byte_cnt <= '0;
                        end else if (rx_dval) begin
                            byte_cnt <= byte_cnt + 16'd1;
                        end
                    end
                    PH_END: begin
                        if (rx_dval && rx_eop) begin
                            phase     <= PH_IDLE;
                            frame_end <= 1'b1;
                        end else if (rx_dval) begin
                            phase <= PH_DONE;
                        end
                    end
                    // Lost eop, close the frame on the next byte slot
                    PH_DONE: begin
                        if (rx_dval) begin
                            phase     <= PH_IDLE;
                            frame_end <= 1'b1;
                        end
                    end
                    default: phase <= PH_IDLE;
                endcase
            end
        end
    end

    // Length field capture, kept across frames
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            body_len <= LEN_RESET;
        end else if (phase == PH_BODY && rx_dval) begin
            if (byte_cnt == LEN_OFS) begin
                body_len[15:8] <= rx_data;
            end else if (byte_cnt == LEN_OFS + 16'd1) begin
                body_len[7:0] <= rx_data;
            end
        end
    end

    // --------------------------------------------------
    // Length error, held until the trailer is out
    // --------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            end_d1 <= 1'b0;
            end_d2 <= 1'b0;
        end else begin
            end_d1 <= frame_end;
            end_d2 <= end_d1;
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            len_err <= 1'b0;
        end else if (end_d2) begin
            len_err <= 1'b0;
        end else if (early_eop) begin
            len_err <= 1'b1;
        end else if (phase == PH_END && rx_dval && (rx_data != END_BYTE || !rx_eop)) begin
            len_err <= 1'b1;
        end
    end

endmodule

/* frame_check/tick_check.sv */
// Tick checker, compares each packet serial number with the previous one plus one
`timescale 1ns/1ns

module tick_check (
    input  logic                    clk_125m,
    input  logic                    rst_125m,
    input  logic                    rx_dval,
    input  macrx_pkg::byte_t        rx_data,
    input  macrx_pkg::frame_phase_t phase,
    input  macrx_pkg::word16_t      byte_cnt,
    output logic                    tick_err
);
    import macrx_pkg::*;

    word16_t      tick_q;
    word16_t      tick_now;
    word16_t      prev_tick;
    frame_phase_t phase_q;
    logic [1:0]   clr_sr;
    logic         body_byte;
    logic         idle_entry;

    assign body_byte  = rx_dval && (phase == PH_BODY);
    assign tick_now   = {tick_q[15:8], rx_data};
    assign idle_entry = (phase == PH_IDLE) && (phase_q != PH_IDLE);

    always_ff @(posedge clk_125m) begin
        if (body_byte && byte_cnt == TICK_OFS) begin
            tick_q[15:8] <= rx_data;
        end else if (body_byte && byte_cnt == TICK_OFS + 16'd1) begin
            tick_q[7:0] <= rx_data;
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            prev_tick <= '0;
        end else if (body_byte && byte_cnt == LEN_OFS) begin
            prev_tick <= tick_q;
        end
    end

    // Frame close seen through the phase, delayed to the end of the trailer
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            phase_q <= PH_IDLE;
            clr_sr  <= 2'b00;
        end else begin
            phase_q <= phase;
            clr_sr  <= {clr_sr[0], idle_entry};
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            tick_err <= 1'b0;
        end else if (clr_sr[1]) begin
            tick_err <= 1'b0;
        end else if (body_byte && byte_cnt == TICK_OFS + 16'd1) begin
            tick_err <= (tick_now != prev_tick + 16'd1);
        end
    end

endmodule

/* frame_check/crc_check.sv */
// CRC checker, runs CRC-32 over body and status bytes and checks it against the FCS
`timescale 1ns/1ns

module crc_check (
    input  logic                    clk_125m,
    input  logic                    rst_125m,
    input  logic                    rx_dval,
    input  logic                    body_start,
    input  macrx_pkg::byte_t        rx_data,
    input  macrx_pkg::frame_phase_t phase,
    output logic                    crc_err
);
    import macrx_pkg::*;

    crc_t         crc_q;
    crc_t         fcs_q;
    frame_phase_t phase_q;
    logic [1:0]   clr_sr;
    logic         idle_entry;
    logic         fcs_done;

    // One byte of reflected CRC-32, LSB first
    function automatic crc_t crc_byte(input crc_t crc_in, input byte_t data);
        crc_t c;
        crc_t poly_r;
        int   i;
        int   b;
        for (i = 0; i < 32; i++) begin
            poly_r[i] = CRC_POLY[31 - i];
        end
        c = crc_in ^ {24'h000000, data};
        for (b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ poly_r) : (c >> 1);
        end
        return c;
    endfunction

    assign idle_entry = (phase == PH_IDLE) && (phase_q != PH_IDLE);
    assign fcs_done   = (phase_q == PH_FCS) && (phase != PH_FCS);

    // --------------------------------------------------
    // Running CRC and FCS shift register
    // --------------------------------------------------
    always_ff @(posedge clk_125m) begin
        if (body_start) begin
            crc_q <= CRC_INIT;
        end else if (rx_dval && (phase == PH_BODY || phase == PH_STATUS)) begin
            crc_q <= crc_byte(crc_q, rx_data);
        end
    end

    // FCS arrives most significant byte first
    always_ff @(posedge clk_125m) begin
        if (rx_dval && phase == PH_FCS) begin
            fcs_q <= {fcs_q[23:0], rx_data};
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            phase_q <= PH_IDLE;
            clr_sr  <= 2'b00;
        end else begin
            phase_q <= phase;
            clr_sr  <= {clr_sr[0], idle_entry};
        end
    end

    // Compare once the last FCS byte has been shifted in
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            crc_err <= 1'b0;
        end else if (clr_sr[1]) begin
            crc_err <= 1'b0;
        end else if (fcs_done) begin
            crc_err <= (fcs_q != ~crc_q);
        end
    end

endmodule

/* src/preamble_detect.sv */
// Preamble detector, flags the start of the body on an SFD after a full preamble
`timescale 1ns/1ns

module preamble_detect (
    input  logic             clk_125m,
    input  logic             rst_125m,
    input  logic             rx_dval,
    input  logic             rx_sop,
    input  macrx_pkg::byte_t rx_data,
    output logic             body_start
);
    import macrx_pkg::*;

    logic       armed;
    logic [3:0] pre_cnt;
    logic       is_pre;

    assign is_pre = rx_dval && (rx_data == PREAMBLE_BYTE);

    // Armed by sop on a preamble byte, any other valid byte drops it
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            armed <= 1'b0;
        end else if (rx_dval && rx_data != PREAMBLE_BYTE) begin
            armed <= 1'b0;
        end else if (rx_sop && is_pre) begin
            armed <= 1'b1;
        end
    end

    // Preamble byte count, saturating so that long preambles never match
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            pre_cnt <= 4'd0;
        end else if (rx_sop && is_pre) begin
            pre_cnt <= 4'd1;
        end else if (armed && is_pre && pre_cnt != 4'hF) begin
            pre_cnt <= pre_cnt + 4'd1;
        end
    end

    assign body_start = armed && rx_dval && (rx_data == SFD_BYTE)
                        && (pre_cnt == PREAMBLE_LEN);

endmodule

/* src/status_append.sv */
// Status appender, forwards body bytes and adds the two-byte status trailer
`timescale 1ns/1ns

module status_append (
    input  logic                    clk_125m,
    input  logic                    rst_125m,
    input  logic                    self_cfg_err,
    input  logic                    rx_dval,
    input  logic                    frame_end,
    input  logic                    len_err,
    input  logic                    tick_err,
    input  logic                    crc_err,
    input  macrx_pkg::byte_t        rx_data,
    input  macrx_pkg::frame_phase_t phase,
    input  macrx_pkg::word16_t      byte_cnt,
    output logic                    fifo_dval,
    output logic                    fifo_sop,
    output logic                    fifo_eop,
    output macrx_pkg::byte_t        fifo_data
);
    import macrx_pkg::*;

    logic [1:0] cfg_sync;
    word16_t    link_sta;
    logic       trail_d;
    logic       body_byte;

    assign body_byte = rx_dval && (phase == PH_BODY);

    // Two-flop synchronizer for the configuration error
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            cfg_sync <= 2'b00;
        end else begin
            cfg_sync <= {cfg_sync[0], self_cfg_err};
        end
    end

    // Link status from the two status bytes
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            link_sta <= '0;
        end else if (rx_dval && phase == PH_STATUS) begin
            if (byte_cnt == 16'd0) begin
                link_sta[15:8] <= rx_data;
            end else if (byte_cnt == 16'd1) begin
                link_sta[7:0] <= rx_data;
            end
        end
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            trail_d   <= 1'b0;
            fifo_dval <= 1'b0;
            fifo_sop  <= 1'b0;
            fifo_eop  <= 1'b0;
        end else begin
            trail_d   <= frame_end;
            fifo_dval <= body_byte || frame_end || trail_d;
            fifo_sop  <= body_byte && (byte_cnt == 16'd0);
            fifo_eop  <= trail_d;
        end
    end

    // Trailer: status high byte, then error flags over the status low nibble
    always_ff @(posedge clk_125m) begin
        if (frame_end) begin
            fifo_data <= link_sta[15:8];
        end else if (trail_d) begin
            fifo_data <= {cfg_sync[1], len_err, tick_err, crc_err, link_sta[3:0]};
        end else begin
            fifo_data <= rx_data;
        end
    end

endmodule

/* src/macrx_top.sv */
// MAC receive top level, registers the PCS byte stream and links the frame checkers
`timescale 1ns/1ns

module macrx_top (
    input  logic             clk_125m,
    input  logic             rst_125m,
    input  logic             self_cfg_err,
    input  logic             pcs_dval,
    input  logic             pcs_sop,
    input  logic             pcs_eop,
    input  macrx_pkg::byte_t pcs_data,
    output logic             fifo_dval,
    output logic             fifo_sop,
    output logic             fifo_eop,
    output macrx_pkg::byte_t fifo_data
);
    import macrx_pkg::*;

    logic         rx_dval;
    logic         rx_sop;
    logic         rx_eop;
    byte_t        rx_data;
    logic         body_start;
    frame_phase_t phase;
    word16_t      byte_cnt;
    logic         frame_end;
    logic         len_err;
    logic         tick_err;
    logic         crc_err;

    // Input stage, every checker works on this copy
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            rx_dval <= 1'b0;
            rx_sop  <= 1'b0;
            rx_eop  <= 1'b0;
        end else begin
            rx_dval <= pcs_dval;
            rx_sop  <= pcs_sop;
            rx_eop  <= pcs_eop;
        end
    end

    always_ff @(posedge clk_125m) begin
        rx_data <= pcs_data;
    end

    preamble_detect preamble_detect_i (.*);
    frame_tracker   frame_tracker_i   (.*);
    tick_check      tick_check_i      (.*);
    crc_check       crc_check_i       (.*);
    status_append   status_append_i   (.*);

endmodule

/* bench/tb_frames.svh */
// MAC receive frame table with the expected trailer flags and the reference CRC-32
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// pre_mode: 0 good, 1 corrupt preamble byte, 2 short preamble, 3 long preamble
// exp_err: trailer bits 7 to 4, that is cfg, len, tick, crc
typedef struct packed {
    logic [15:0] body_len;
    logic [15:0] tick;
    logic [15:0] status;
    logic [1:0]  pre_mode;
    logic        bad_fcs;
    logic        bad_end;
    logic        no_eop;
    logic        cfg_err;
    logic [3:0]  exp_err;
} frame_desc_t;

localparam int NUM_FRAMES = 13;

localparam frame_desc_t FRAMES [NUM_FRAMES] = '{
    '{16'd20, 16'd1,  16'hA5C3, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd32, 16'd2,  16'h3C5A, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0, 4'b0001},
    '{16'd16, 16'd3,  16'h0F0E, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd24, 16'd5,  16'h1234, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0010},
    '{16'd18, 16'd6,  16'hBEEF, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 4'b0100},
    '{16'd22, 16'd7,  16'h7E81, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 4'b0100},
    '{16'd20, 16'd8,  16'h4D2B, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd20, 16'd9,  16'h1111, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd20, 16'd9,  16'h2222, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd20, 16'd9,  16'h3333, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd26, 16'd9,  16'h9C06, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 4'b1000},
    '{16'd14, 16'd10, 16'h6A57, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000},
    '{16'd48, 16'd11, 16'hC0DE, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000}
};

// Standard CRC-32, one data bit at a time, LSB first
function automatic crc_t crc32_update(input crc_t crc, input byte_t data);
    crc_t c;
    int   n;
    c = crc;
    for (n = 0; n < 8; n++) begin
        if (c[0] ^ data[n]) begin
            c = (c >> 1) ^ 32'hEDB88320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

`endif

/* bench/tb_macrx.sv */
// Testbench for the MAC receive path that drives framed PCS bytes and checks the FIFO stream
`timescale 1ns/1ns

module tb_macrx;
    import macrx_pkg::*;

    localparam int GAP_CYCLES   = 6;
    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 200;

    `include "tb_frames.svh"

    logic        clk_125m = 1'b0;
    logic        rst_125m;
    logic        self_cfg_err;
    logic        pcs_dval;
    logic        pcs_sop;
    logic        pcs_eop;
    byte_t       pcs_data;
    logic        fifo_dval;
    logic        fifo_sop;
    logic        fifo_eop;
    byte_t       fifo_data;

    // Stimulus entry is dval, sop, eop, self_cfg_err, data
    logic [11:0] stim_q[$];
    // Expected output entry is sop, eop, data
    logic [9:0]  exp_q[$];
    logic [15:0] lfsr;
    logic        cur_cfg;
    int          rd_idx     = 0;
    int          mon_errors = 0;
    int          run_errors = 0;
    int          cycle_cnt  = 0;
    int          max_cycles = 1000000;

    macrx_top macrx_top_i (.*);

    always #4 clk_125m = ~clk_125m;

    // --------------------------------------------------
    // Stimulus generation
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_byte(output byte_t b);
        int n;
        b = '0;
        for (n = 0; n < 8; n++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic add_frame(input frame_desc_t fd);
        int    pre_n;
        int    j;
        byte_t b;
        crc_t  crc;
        crc_t  fcs;
        logic  keep;
        pre_n = (fd.pre_mode == 2'd2) ? 6 : (fd.pre_mode == 2'd3) ? 8 : 7;
        keep  = (fd.pre_mode == 2'd0);
        for (j = 0; j < pre_n; j++) begin
            b = (fd.pre_mode == 2'd1 && j == 3) ? 8'h54 : PREAMBLE_BYTE;
            stim_q.push_back({1'b1, j == 0, 1'b0, cur_cfg, b});
        end
        // Config error follows the frame from its SFD on
        cur_cfg = fd.cfg_err;
        stim_q.push_back({3'b100, cur_cfg, SFD_BYTE});
        crc = CRC_INIT;
        for (j = 0; j < int'(fd.body_len); j++) begin
            rand_byte(b);
            if (j == int'(TICK_OFS)) begin
                b = fd.tick[15:8];
            end else if (j == int'(TICK_OFS) + 1) begin
                b = fd.tick[7:0];
            end else if (j == int'(LEN_OFS)) begin
                b = fd.body_len[15:8];
            end else if (j == int'(LEN_OFS) + 1) begin
                b = fd.body_len[7:0];
            end
            crc = crc32_update(crc, b);
            stim_q.push_back({3'b100, cur_cfg, b});
            if (keep) begin
                exp_q.push_back({j == 0, 1'b0, b});
            end
        end
        crc = crc32_update(crc, fd.status[15:8]);
        crc = crc32_update(crc, fd.status[7:0]);
        stim_q.push_back({3'b100, cur_cfg, fd.status[15:8]});
        stim_q.push_back({3'b100, cur_cfg, fd.status[7:0]});
        fcs = ~crc;
        if (fd.bad_fcs) begin
            fcs[15:8] = ~fcs[15:8];
        end
        for (j = 3; j >= 0; j--) begin
            stim_q.push_back({3'b100, cur_cfg, fcs[8*j +: 8]});
        end
        b = fd.bad_end ? 8'hFE : END_BYTE;
        stim_q.push_back({1'b1, 1'b0, ~fd.no_eop, cur_cfg, b});
        for (j = 0; j < GAP_CYCLES; j++) begin
            stim_q.push_back({3'b000, cur_cfg, 8'h00});
        end
        if (keep) begin
            exp_q.push_back({2'b00, fd.status[15:8]});
            exp_q.push_back({2'b01, fd.exp_err, fd.status[3:0]});
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int f;
        int k;
        rst_125m     = 1'b0;
        self_cfg_err = 1'b0;
        pcs_dval     = 1'b0;
        pcs_sop      = 1'b0;
        pcs_eop      = 1'b0;
        pcs_data     = 8'h00;
        lfsr         = 16'd46;
        cur_cfg      = 1'b0;
        for (f = 0; f < NUM_FRAMES; f++) begin
            add_frame(FRAMES[f]);
        end
        max_cycles = RESET_CYCLES + stim_q.size() + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk_125m);
        if (fifo_dval || fifo_sop || fifo_eop) begin
            run_errors++;
            $display("Mismatch at %0t ns: FIFO strobes active during reset", $time);
        end
        rst_125m <= 1'b1;
        repeat (2) @(posedge clk_125m);
        for (k = 0; k < stim_q.size(); k++) begin
            @(posedge clk_125m);
            {pcs_dval, pcs_sop, pcs_eop, self_cfg_err, pcs_data} <= stim_q[k];
        end
        // Wait for the last expected byte to leave the DUT
        while (rd_idx < exp_q.size()) begin
            @(posedge clk_125m);
        end
        repeat (20) @(posedge clk_125m);
        $display("Run done: %0d bytes checked, %0d output errors, %0d other errors",
                 rd_idx, mon_errors, run_errors);
        if (mon_errors == 0 && run_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Output monitor on the falling edge
    always @(negedge clk_125m) begin
        if (rst_125m && fifo_dval) begin
            if (rd_idx >= exp_q.size()) begin
                mon_errors++;
                $display("Unexpected output byte %02h at %0t ns, nothing was pending",
                         fifo_data, $time);
            end else begin
                if ({fifo_sop, fifo_eop, fifo_data} !== exp_q[rd_idx]) begin
                    mon_errors++;
                    $display("Mismatch at %0t ns: byte %0d got sop %b eop %b data %02h",
                             $time, rd_idx, fifo_sop, fifo_eop, fifo_data);
                    $display("    expected sop %b eop %b data %02h",
                             exp_q[rd_idx][9], exp_q[rd_idx][8], exp_q[rd_idx][7:0]);
                end
                rd_idx++;
            end
        end else if (rst_125m && (fifo_sop || fifo_eop)) begin
            mon_errors++;
            $display("Mismatch at %0t ns: output sop or eop set without dval", $time);
        end
    end

    always @(posedge clk_125m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout after %0d cycles, %0d of %0d output bytes seen",
                     cycle_cnt, rd_idx, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+bench
common/macrx_pkg.sv
frame_check/frame_tracker.sv
frame_check/tick_check.sv
frame_check/crc_check.sv
src/preamble_detect.sv
src/status_append.sv
src/macrx_top.sv
bench/tb_macrx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MAC receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_macrx -o sim_macrx
./obj_dir/sim_macrx > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
